// ==== vlog.f ====
rtl/cbf_pkg.sv
rtl/sp_hash.sv
rtl/hash_block.sv
rtl/updown_counter.sv
rtl/cb_filter.sv
bench/cb_filter_tb.sv

// ==== Makefile ====
TOP := cb_filter_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): vlog.f rtl/*.sv bench/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f vlog.f -Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/cb_filter_tb.sv ====
// counting bloom filter testbench
`timescale 1ns/1ps
`default_nettype none

module cb_filter_tb;

  logic            clk_i;
  logic            reset_i;
  cbf_pkg::key_t   look_data_i;
  logic            look_valid_o;
  cbf_pkg::key_t   incr_data_i;
  logic            incr_valid_i;
  cbf_pkg::key_t   decr_data_i;
  logic            decr_valid_i;
  logic            filter_clear_i;
  cbf_pkg::usage_t filter_usage_o;
  logic            filter_full_o;
  logic            filter_empty_o;
  logic            filter_error_o;

  int unsigned     errors = 0;
  int unsigned     checks = 0;
  logic [31:0]     rng_state = 32'ha7fcf976;
  // scoreboard of held keys, their multiplicities and the item count mod 16
  cbf_pkg::key_t   sb_keys[$];
  int unsigned     sb_mult[$];
  cbf_pkg::usage_t exp_usage;

  cb_filter dut (.*);

  always #20 clk_i = ~clk_i;

  // ----------------------------------------
  // concurrent checks
  // ----------------------------------------
  // error holds until a clear
  assert property (@(posedge clk_i) disable iff (reset_i)
    (filter_error_o && !filter_clear_i) |=> filter_error_o)
  else begin
    $display("[FAIL] %0t filter_error_o expected 1 got 0", $time);
    errors++;
  end

  // a saturated bucket cannot coexist with an empty filter
  assert property (@(posedge clk_i) disable iff (reset_i)
    !(filter_full_o && filter_empty_o))
  else begin
    $display("[FAIL] %0t filter_empty_o expected 0 got 1", $time);
    errors++;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_key(output cbf_pkg::key_t k);
    rng_state = xorshift32(rng_state);
    k = rng_state;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected)
    else begin
      $display("[FAIL] %0t %s expected %0h got %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  function automatic void add_key(input cbf_pkg::key_t k);
    foreach (sb_keys[i]) begin
      if (sb_keys[i] == k) begin
        sb_mult[i]++;
        return;
      end
    end
    sb_keys.push_back(k);
    sb_mult.push_back(1);
  endfunction

  // one copy of the oldest key leaves the scoreboard
  function automatic void drop_first();
    sb_mult[0]--;
    if (sb_mult[0] == 0) begin
      void'(sb_keys.pop_front());
      void'(sb_mult.pop_front());
    end
  endfunction

  // strobes for one cycle, returns right after the sampling edge
  task automatic apply_strobes(input logic inc, input cbf_pkg::key_t inc_key,
                               input logic dec, input cbf_pkg::key_t dec_key);
    @(posedge clk_i);
    incr_valid_i <= inc;
    incr_data_i  <= inc_key;
    decr_valid_i <= dec;
    decr_data_i  <= dec_key;
    @(posedge clk_i);
    incr_valid_i <= 1'b0;
    decr_valid_i <= 1'b0;
    // the item count only moves on an unpaired strobe
    if (inc && !dec) exp_usage = exp_usage + cbf_pkg::usage_t'(1);
    if (dec && !inc) exp_usage = exp_usage - cbf_pkg::usage_t'(1);
  endtask

  task automatic clear_filter();
    @(posedge clk_i);
    filter_clear_i <= 1'b1;
    @(posedge clk_i);
    filter_clear_i <= 1'b0;
    sb_keys.delete();
    sb_mult.delete();
    exp_usage = '0;
  endtask

  task automatic lookup_expect(input cbf_pkg::key_t k, input logic expected);
    @(posedge clk_i);
    look_data_i <= k;
    @(negedge clk_i);
    check_value("look_valid_o", 32'(expected), 32'(look_valid_o));
  endtask

  // no false negatives for anything still held
  task automatic check_members();
    foreach (sb_keys[i]) lookup_expect(sb_keys[i], 1'b1);
  endtask

  function automatic logic flag_value(input int sel);
    case (sel)
      0:       return filter_full_o;
      1:       return filter_empty_o;
      default: return filter_error_o;
    endcase
  endfunction

  // polls at falling edges until the flag is high or the budget runs out
  task automatic wait_flag(input string name, input int sel, input int max_cycles);
    int   n;
    logic v;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
      v = flag_value(sel);
    end while (v !== 1'b1 && n < max_cycles);
    if (v !== 1'b1) begin
      $display("timeout: %s did not rise within %0d cycles at %0t", name, max_cycles, $time);
      errors++;
    end
  endtask

  task automatic check_reset_state();
    cbf_pkg::key_t k;
    @(negedge clk_i);
    check_value("filter_empty_o", 1, filter_empty_o);
    check_value("filter_usage_o", 0, filter_usage_o);
    check_value("filter_full_o", 0, filter_full_o);
    check_value("filter_error_o", 0, filter_error_o);
    // an all zero filter answers no for any key
    repeat (4) begin
      next_key(k);
      lookup_expect(k, 1'b0);
    end
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin : main
    cbf_pkg::key_t   k;
    cbf_pkg::key_t   removed[$];
    cbf_pkg::usage_t usage_before;
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    look_data_i    = '0;
    incr_data_i    = '0;
    incr_valid_i   = 1'b0;
    decr_data_i    = '0;
    decr_valid_i   = 1'b0;
    filter_clear_i = 1'b0;
    exp_usage      = '0;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    check_reset_state();

    // eight inserts, every held key must stay visible
    repeat (8) begin
      next_key(k);
      apply_strobes(1'b1, k, 1'b0, '0);
      add_key(k);
      @(negedge clk_i);
      check_value("filter_usage_o", 32'(exp_usage), 32'(filter_usage_o));
      check_value("filter_empty_o", 0, filter_empty_o);
      check_members();
    end

    // insert a new key while removing an old one
    next_key(k);
    usage_before = exp_usage;
    apply_strobes(1'b1, k, 1'b1, sb_keys[0]);
    drop_first();
    add_key(k);
    @(negedge clk_i);
    check_value("filter_usage_o", 32'(usage_before), 32'(filter_usage_o));
    check_members();
    // same key on both strobes is a no-op
    k = sb_keys[0];
    apply_strobes(1'b1, k, 1'b1, k);
    @(negedge clk_i);
    check_value("filter_usage_o", 32'(usage_before), 32'(filter_usage_o));
    lookup_expect(k, 1'b1);

    // remove every stored copy
    while (sb_keys.size() > 0) begin
      k = sb_keys[0];
      removed.push_back(k);
      apply_strobes(1'b0, '0, 1'b1, k);
      drop_first();
    end
    wait_flag("filter_empty_o", 1, 4);
    check_value("filter_usage_o", 0, filter_usage_o);
    foreach (removed[i]) lookup_expect(removed[i], 1'b0);

    // fifteen copies saturate the key's buckets, the sixteenth wraps them
    clear_filter();
    next_key(k);
    repeat (15) begin
      apply_strobes(1'b1, k, 1'b0, '0);
      add_key(k);
    end
    wait_flag("filter_full_o", 0, 4);
    check_value("filter_error_o", 0, filter_error_o);
    check_value("filter_usage_o", 32'(exp_usage), 32'(filter_usage_o));
    apply_strobes(1'b1, k, 1'b0, '0);
    wait_flag("filter_error_o", 2, 4);
    check_value("filter_usage_o", 32'(exp_usage), 32'(filter_usage_o));
    repeat (6) begin
      @(negedge clk_i);
      check_value("filter_error_o", 1, filter_error_o);
    end

    // clear brings back the reset state
    clear_filter();
    check_reset_state();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/cb_filter.sv ====
// counting bloom filter top level
`timescale 1ns/1ps
`default_nettype none

module cb_filter (
  input  logic            clk_i,
  input  logic            reset_i,
  // membership lookup
  input  cbf_pkg::key_t   look_data_i,
  output logic            look_valid_o,
  // insert a key
  input  cbf_pkg::key_t   incr_data_i,
  input  logic            incr_valid_i,
  // remove a key
  input  cbf_pkg::key_t   decr_data_i,
  input  logic            decr_valid_i,
  // status
  input  logic            filter_clear_i,
  output cbf_pkg::usage_t filter_usage_o,
  output logic            filter_full_o,
  output logic            filter_empty_o,
  output logic            filter_error_o
);

  // bucket indicators from the three hash blocks
  cbf_pkg::bucket_vec_t look_ind;
  cbf_pkg::bucket_vec_t incr_ind;
  cbf_pkg::bucket_vec_t decr_ind;
  // per bucket control and status
  cbf_pkg::bucket_vec_t bucket_en;
  cbf_pkg::bucket_vec_t bucket_down;
  cbf_pkg::bucket_vec_t bucket_occupied;
  cbf_pkg::bucket_vec_t bucket_saturated;
  cbf_pkg::bucket_vec_t bucket_wrap;
  // item count control
  logic                 usage_en;
  logic                 usage_wrap;
  logic                 error_q;

  // ----------------------------------------
  // lookup
  // ----------------------------------------
  hash_block i_look_hashes (
    .key_i       ( look_data_i ),
    .indicator_o ( look_ind    )
  );

  // member only if every selected bucket holds something
  // the indicator always has a bit set, so an empty filter answers 0
  assign look_valid_o = ((look_ind & bucket_occupied) == look_ind);

  // ----------------------------------------
  // increment and decrement hashing
  // ----------------------------------------
  hash_block i_incr_hashes (
    .key_i       ( incr_data_i ),
    .indicator_o ( incr_ind    )
  );

  hash_block i_decr_hashes (
    .key_i       ( decr_data_i ),
    .indicator_o ( decr_ind    )
  );

  // ----------------------------------------
  // bucket control
  // ----------------------------------------
  // direction only matters where a bucket is enabled
  assign bucket_down = decr_valid_i ? decr_ind : '0;

  always_comb begin : proc_bucket_en
    unique case ({incr_valid_i, decr_valid_i})
      2'b10:   bucket_en = incr_ind;
      2'b01:   bucket_en = decr_ind;
      // buckets hit by both strobes would cancel out, so leave them alone
      2'b11:   bucket_en = incr_ind ^ decr_ind;
      default: bucket_en = '0;
    endcase
  end

  for (genvar b = 0; b < cbf_pkg::NoBuckets; b++) begin : gen_buckets
    logic [cbf_pkg::BucketWidth-1:0] bucket_count;

    updown_counter #(
      .Width   ( cbf_pkg::BucketWidth )
    ) i_bucket (
      .clk_i   ( clk_i                ),
      .reset_i ( reset_i              ),
      .clear_i ( filter_clear_i       ),
      .en_i    ( bucket_en[b]         ),
      .down_i  ( bucket_down[b]       ),
      .count_o ( bucket_count         ),
      .wrap_o  ( bucket_wrap[b]       )
    );

    assign bucket_occupied[b]  = |bucket_count;
    assign bucket_saturated[b] = &bucket_count;
  end

  // ----------------------------------------
  // item count
  // ----------------------------------------
  // simultaneous insert and remove leave the count where it is
  assign usage_en = incr_valid_i ^ decr_valid_i;

  updown_counter #(
    .Width   ( cbf_pkg::UsageWidth )
  ) i_usage (
    .clk_i   ( clk_i               ),
    .reset_i ( reset_i             ),
    .clear_i ( filter_clear_i      ),
    .en_i    ( usage_en            ),
    .down_i  ( decr_valid_i        ),
    .count_o ( filter_usage_o      ),
    .wrap_o  ( usage_wrap          )
  );

  // ----------------------------------------
  // status flags
  // ----------------------------------------
  // full once any bucket can take no further increment
  assign filter_full_o  = |bucket_saturated;
  assign filter_empty_o = ~|bucket_occupied;

  // sticky until clear, any wrap means the contents can no longer be trusted
  always_ff @(posedge clk_i) begin
    if (reset_i || filter_clear_i) begin
      error_q <= 1'b0;
    end else if ((|bucket_wrap) || usage_wrap) begin
      error_q <= 1'b1;
    end
  end

  assign filter_error_o = error_q;

endmodule

`default_nettype wire

// ==== rtl/updown_counter.sv ====
// up/down counter with wrap flag
`timescale 1ns/1ps
`default_nettype none

module updown_counter #(
  parameter int unsigned Width = 4
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             clear_i,
  input  logic             en_i,
  input  logic             down_i,
  output logic [Width-1:0] count_o,
  output logic             wrap_o
);

  logic [Width-1:0] count_q;
  logic             at_max;
  logic             at_min;

  // ----------------------------------------
  // count register
  // ----------------------------------------
  // clear wins over a pending count step
  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      count_q <= '0;
    end else if (en_i) begin
      // modulo 2**Width in both directions
      if (down_i) begin
        count_q <= count_q - 1'b1;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // wrap detection
  // ----------------------------------------
  assign at_max = &count_q;
  assign at_min = ~|count_q;

  // high in the cycle before the value rolls over
  assign wrap_o  = en_i & (down_i ? at_min : at_max);
  assign count_o = count_q;

endmodule

`default_nettype wire

// ==== rtl/hash_block.sv ====
// combined bucket indicator of all hashes
`timescale 1ns/1ps
`default_nettype none

module hash_block (
  input  cbf_pkg::key_t        key_i,
  output cbf_pkg::bucket_vec_t indicator_o
);

  // one-hot select from every hash function
  cbf_pkg::bucket_vec_t [cbf_pkg::KHashes-1:0] selects;

  // ----------------------------------------
  // seeded hash instances
  // ----------------------------------------
  for (genvar h = 0; h < cbf_pkg::KHashes; h++) begin : gen_hashes
    // each hash gets its own seed pair, so the selects are independent
    sp_hash #(
      .PermuteKey ( cbf_pkg::PermuteSeeds[h] ),
      .XorKey     ( cbf_pkg::XorSeeds[h]     )
    ) i_sp_hash (
      .key_i      ( key_i                    ),
      .onehot_o   ( selects[h]               )
    );
  end

  // ----------------------------------------
  // indicator merge
  // ----------------------------------------
  // colliding hashes leave fewer than KHashes bits set
  // but never zero bits
  always_comb begin : proc_merge
    indicator_o = '0;
    for (int unsigned h = 0; h < cbf_pkg::KHashes; h++) begin
      indicator_o = indicator_o | selects[h];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/sp_hash.sv ====
// keyed substitution-permutation hash
`timescale 1ns/1ps
`default_nettype none

module sp_hash #(
  parameter logic [31:0] PermuteKey = 32'h5f2c_91e3,
  parameter logic [31:0] XorKey     = 32'h9b1e_6a45
) (
  input  cbf_pkg::key_t        key_i,
  output cbf_pkg::bucket_vec_t onehot_o
);

  // ----------------------------------------
  // permutation table
  // ----------------------------------------
  // fisher-yates shuffle of the bit positions, driven by a galois lfsr
  // evaluated once at elaboration, so the wiring is fixed per instance
  function automatic logic [cbf_pkg::KeyWidth-1:0][cbf_pkg::KeyIdxWidth-1:0] gen_perm(
    input logic [31:0] seed
  );
    logic [cbf_pkg::KeyWidth-1:0][cbf_pkg::KeyIdxWidth-1:0] perm;
    logic [cbf_pkg::KeyIdxWidth-1:0]                         tmp;
    logic [31:0]                                             lfsr;
    int unsigned                                             j;
    // identity to start with
    for (int unsigned i = 0; i < cbf_pkg::KeyWidth; i++) begin
      perm[i] = cbf_pkg::KeyIdxWidth'(i);
    end
    // an all-zero lfsr would lock up
    lfsr = (seed == '0) ? 32'h0000_0001 : seed;
    for (int unsigned i = cbf_pkg::KeyWidth - 1; i > 0; i--) begin
      // x^32 + x^22 + x^2 + x + 1, right shifting form
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
      j = lfsr % (i + 1);
      tmp     = perm[i];
      perm[i] = perm[j];
      perm[j] = tmp;
    end
    return perm;
  endfunction

  localparam logic [cbf_pkg::KeyWidth-1:0][cbf_pkg::KeyIdxWidth-1:0] Perm =
    gen_perm(PermuteKey);

  // output bit b takes input bit Perm[b]
  function automatic cbf_pkg::key_t permute(input cbf_pkg::key_t din);
    cbf_pkg::key_t dout;
    for (int unsigned b = 0; b < cbf_pkg::KeyWidth; b++) begin
      dout[b] = din[Perm[b]];
    end
    return dout;
  endfunction

  // ----------------------------------------
  // rounds, fold and decode
  // ----------------------------------------
  cbf_pkg::key_t                 mixed;
  logic [cbf_pkg::HashWidth-1:0] index;

  always_comb begin : proc_rounds
    mixed = key_i;
    // each round scatters the bits and then flips them with the key
    for (int unsigned r = 0; r < cbf_pkg::HashRounds; r++) begin
      mixed = permute(mixed) ^ XorKey;
    end
  end

  // xor every index-wide slice of the mixed word together
  always_comb begin : proc_fold
    index = '0;
    for (int unsigned s = 0; s < cbf_pkg::KeyWidth / cbf_pkg::HashWidth; s++) begin
      index = index ^ mixed[s*cbf_pkg::HashWidth +: cbf_pkg::HashWidth];
    end
  end

  // exactly one bucket selected per key
  assign onehot_o = cbf_pkg::bucket_vec_t'(1) << index;

endmodule

`default_nettype wire

// ==== rtl/cbf_pkg.sv ====
// counting bloom filter definitions
`default_nettype none

package cbf_pkg;

  // ----------------------------------------
  // filter geometry
  // ----------------------------------------
  // independent hash functions per key
  localparam int unsigned KHashes     = 3;
  // bucket index width, one bucket per index value
  localparam int unsigned HashWidth   = 4;
  localparam int unsigned NoBuckets   = 2 ** HashWidth;
  // substitution-permutation rounds inside each hash
  localparam int unsigned HashRounds  = 1;
  localparam int unsigned KeyWidth    = 32;
  // bit index into a key, used by the permutation tables
  localparam int unsigned KeyIdxWidth = $clog2(KeyWidth);
  // per bucket counter width, saturates visibly at all ones
  localparam int unsigned BucketWidth = 4;
  // item count is as wide as a bucket index
  localparam int unsigned UsageWidth  = HashWidth;

  // ----------------------------------------
  // vector types
  // ----------------------------------------
  typedef logic [KeyWidth-1:0]   key_t;
  // one bit per bucket, for indicators and per bucket flags
  typedef logic [NoBuckets-1:0]  bucket_vec_t;
  typedef logic [UsageWidth-1:0] usage_t;

  // ----------------------------------------
  // hash seeds
  // ----------------------------------------
  // entry 0 is the rightmost word of each table
  localparam logic [KHashes-1:0][31:0] PermuteSeeds = {
    32'hc3e8_27d9,
    32'h1d7a_4b06,
    32'h5f2c_91e3
  };
  // whitening words applied after every permutation round
  localparam logic [KHashes-1:0][31:0] XorSeeds = {
    32'h6a59_3e17,
    32'h0f73_d2c8,
    32'h9b1e_6a45
  };

endpackage

`default_nettype wire
